// ==== include/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_STRB_W (`LSU_DATA_W / 8)

// l1d geometry, one word per line
`define L1D_IDX_W 6
`define L1D_LINES (1 << `L1D_IDX_W)
`define L1D_TAG_W (`LSU_ADDR_W - `L1D_IDX_W - 2)

// data memory depth in words
`define DMEM_WORDS 1024

`endif

// ==== source/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

  // memory operation issued to the load/store unit
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LBU  = 4'd2,
    LH   = 4'd3,
    LHU  = 4'd4,
    LW   = 4'd5,
    SB   = 4'd6,
    SH   = 4'd7,
    SW   = 4'd8
  } mem_op_e;

  // request driven by a bus peer, held until done
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
    logic [`LSU_STRB_W-1:0] wstrb;
  } bus_req_t;

  // response from memory, done is a one cycle pulse
  typedef struct packed {
    logic                   done;
    logic [`LSU_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

// ==== source/lsu_l1d.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_l1d (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`LSU_ADDR_W-1:0] lookup_addr_i,
  output logic                   hit_o,
  output logic [`LSU_DATA_W-1:0] hit_data_o,
  input  logic                   fill_i,
  input  logic [`LSU_ADDR_W-1:0] fill_addr_i,
  input  logic [`LSU_DATA_W-1:0] fill_data_i,
  input  logic                   inval_i,
  input  logic [`LSU_ADDR_W-1:0] inval_addr_i
);

  logic [`LSU_DATA_W-1:0] data_q [`L1D_LINES];
  logic [`L1D_TAG_W-1:0]  tag_q  [`L1D_LINES];
  logic [`L1D_LINES-1:0]  valid_q;

  logic [`L1D_IDX_W-1:0] lookup_idx;
  logic [`L1D_TAG_W-1:0] lookup_tag;
  logic [`L1D_IDX_W-1:0] fill_idx;
  logic [`L1D_TAG_W-1:0] fill_tag;
  logic [`L1D_IDX_W-1:0] inval_idx;

  // index sits just above the byte offset, tag above that
  assign lookup_idx = lookup_addr_i[`L1D_IDX_W+1:2];
  assign lookup_tag = lookup_addr_i[`LSU_ADDR_W-1:`L1D_IDX_W+2];
  assign fill_idx   = fill_addr_i[`L1D_IDX_W+1:2];
  assign fill_tag   = fill_addr_i[`LSU_ADDR_W-1:`L1D_IDX_W+2];
  assign inval_idx  = inval_addr_i[`L1D_IDX_W+1:2];

  assign hit_o      = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign hit_data_o = data_q[lookup_idx];

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_q <= '0;
    end
    else
    begin
      if (fill_i)
      begin
        valid_q[fill_idx] <= 1'b1;
      end
      // a store to the same line overrides the fill
      if (inval_i)
      begin
        valid_q[inval_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      data_q[fill_idx] <= fill_data_i;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

endmodule

// ==== source/lsu_unit.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_unit (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   lsu_valid_i,
  input  lsu_pkg::mem_op_e       lsu_op_i,
  input  logic [`LSU_ADDR_W-1:0] lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  output logic [`LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_done_o,
  output lsu_pkg::bus_req_t      bus_req_o,
  input  lsu_pkg::bus_rsp_t      bus_rsp_i
);

  import lsu_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } lsu_state_e;

  lsu_state_e state_q;

  logic                   is_load;
  logic                   is_store;
  logic [1:0]             byte_off;
  logic [`LSU_STRB_W-1:0] size_mask;
  logic [`LSU_STRB_W-1:0] wstrb;
  logic [`LSU_DATA_W-1:0] wdata;
  logic                   hit;
  logic [`LSU_DATA_W-1:0] hit_data;
  logic                   hit_done;
  logic                   bus_go;
  logic [`LSU_DATA_W-1:0] word;
  logic [`LSU_DATA_W-1:0] shifted;

  assign is_load  = (lsu_op_i == LB) || (lsu_op_i == LBU) || (lsu_op_i == LH) ||
                    (lsu_op_i == LHU) || (lsu_op_i == LW);
  assign is_store = (lsu_op_i == SB) || (lsu_op_i == SH) || (lsu_op_i == SW);
  assign byte_off = lsu_addr_i[1:0];

  always_comb
  begin
    case (lsu_op_i)
      SB:      size_mask = 4'b0001;
      SH:      size_mask = 4'b0011;
      SW:      size_mask = 4'b1111;
      default: size_mask = 4'b0000;
    endcase
  end

  // lane placement by byte offset, accesses are aligned
  assign wstrb = size_mask << byte_off;
  assign wdata = lsu_wdata_i << {byte_off, 3'b000};

  lsu_l1d u_lsu_l1d (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .lookup_addr_i (lsu_addr_i),
    .hit_o         (hit),
    .hit_data_o    (hit_data),
    .fill_i        (is_load && bus_rsp_i.done),
    .fill_addr_i   (lsu_addr_i),
    .fill_data_i   (bus_rsp_i.rdata),
    .inval_i       (lsu_valid_i && is_store && (state_q == ST_IDLE)),
    .inval_addr_i  (lsu_addr_i)
  );

  // hit answers in the first cycle, without the bus
  assign hit_done = lsu_valid_i && is_load && hit && (state_q == ST_IDLE);
  assign bus_go   = lsu_valid_i &&
                    ((state_q == ST_WAIT) || is_store || (is_load && !hit));

  assign bus_req_o = '{valid: bus_go,
                       write: is_store,
                       addr:  lsu_addr_i,
                       wdata: wdata,
                       wstrb: wstrb};

  assign lsu_done_o = hit_done || bus_rsp_i.done;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state_q <= ST_IDLE;
    end
    else if (bus_rsp_i.done)
    begin
      state_q <= ST_IDLE;
    end
    else if (bus_go)
    begin
      state_q <= ST_WAIT;
    end
  end

  assign word    = bus_rsp_i.done ? bus_rsp_i.rdata : hit_data;
  assign shifted = word >> {byte_off, 3'b000};

  // sign or zero extension of the selected lane
  always_comb
  begin
    case (lsu_op_i)
      LB:      lsu_rdata_o = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
      LBU:     lsu_rdata_o = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
      LH:      lsu_rdata_o = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
      LHU:     lsu_rdata_o = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
      LW:      lsu_rdata_o = word;
      default: lsu_rdata_o = '0;
    endcase
  end

endmodule

// ==== source/fetch_port.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module fetch_port (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   fetch_en_i,
  input  logic [`LSU_ADDR_W-1:0] fetch_pc_i,
  output logic [`LSU_DATA_W-1:0] fetch_instr_o,
  output logic [`LSU_ADDR_W-1:0] fetch_addr_o,
  output logic                   fetch_valid_o,
  output lsu_pkg::bus_req_t      bus_req_o,
  input  lsu_pkg::bus_rsp_t      bus_rsp_i
);

  logic                   en_q;
  logic                   busy_q;
  logic [`LSU_ADDR_W-1:0] pc_q;
  logic                   start;
  logic                   issue;

  assign start = fetch_en_i && !en_q;
  // once raised, a read stays up until its done even if enable drops
  assign issue = busy_q || (fetch_en_i && en_q);

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      en_q   <= 1'b0;
      busy_q <= 1'b0;
    end
    else
    begin
      en_q <= fetch_en_i;
      if (bus_rsp_i.done)
      begin
        busy_q <= 1'b0;
      end
      else if (issue)
      begin
        busy_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      pc_q <= fetch_pc_i;
    end
    else if (bus_rsp_i.done)
    begin
      pc_q <= pc_q + `LSU_ADDR_W'd4;
    end
  end

  assign bus_req_o = '{valid: issue, write: 1'b0, addr: pc_q, wdata: '0, wstrb: '0};

  assign fetch_instr_o = bus_rsp_i.rdata;
  assign fetch_addr_o  = pc_q;
  assign fetch_valid_o = bus_rsp_i.done;

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
  input  logic              clk,
  input  logic              rst_n_i,
  input  lsu_pkg::bus_req_t lsu_req_i,
  input  lsu_pkg::bus_req_t fetch_req_i,
  output lsu_pkg::bus_rsp_t lsu_rsp_o,
  output lsu_pkg::bus_rsp_t fetch_rsp_o,
  output lsu_pkg::bus_req_t mem_req_o,
  input  lsu_pkg::bus_rsp_t mem_rsp_i
);

  logic gnt_hold_q;
  logic gnt_fetch_q;
  logic last_lsu_q;
  logic sel_fetch;

  // held grant first, then lsu priority unless lsu was just served
  assign sel_fetch = gnt_hold_q ? gnt_fetch_q :
                     (fetch_req_i.valid && (!lsu_req_i.valid || last_lsu_q));

  assign mem_req_o = sel_fetch ? fetch_req_i : lsu_req_i;

  assign lsu_rsp_o   = '{done: mem_rsp_i.done && !sel_fetch, rdata: mem_rsp_i.rdata};
  assign fetch_rsp_o = '{done: mem_rsp_i.done && sel_fetch, rdata: mem_rsp_i.rdata};

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      gnt_hold_q  <= 1'b0;
      gnt_fetch_q <= 1'b0;
      last_lsu_q  <= 1'b0;
    end
    else
    begin
      // only meaningful in the cycle right after a done
      last_lsu_q <= mem_rsp_i.done && !sel_fetch;
      if (mem_rsp_i.done)
      begin
        gnt_hold_q <= 1'b0;
      end
      else if (mem_req_o.valid)
      begin
        gnt_hold_q  <= 1'b1;
        gnt_fetch_q <= sel_fetch;
      end
    end
  end

endmodule

// ==== source/data_mem.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module data_mem (
  input  logic              clk,
  input  logic              rst_n_i,
  input  lsu_pkg::bus_req_t req_i,
  output lsu_pkg::bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [`LSU_DATA_W-1:0] mem_q [`DMEM_WORDS];
  logic [`LSU_DATA_W-1:0] rdata_q;
  logic                   done_q;
  logic                   accept;
  logic [IDX_W-1:0]       idx;

  // word address, wraps at the depth
  assign idx = req_i.addr[IDX_W+1:2];

  // the held request is still up in its done cycle, skip it there
  assign accept = req_i.valid && !done_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= accept;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      rdata_q <= mem_q[idx];
      if (req_i.write)
      begin
        for (int b = 0; b < `LSU_STRB_W; b++)
        begin
          if (req_i.wstrb[b])
          begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp_o = '{done: done_q, rdata: rdata_q};

endmodule

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module mem_subsys_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   lsu_valid_i,
  input  lsu_pkg::mem_op_e       lsu_op_i,
  input  logic [`LSU_ADDR_W-1:0] lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  output logic [`LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_done_o,
  input  logic                   fetch_en_i,
  input  logic [`LSU_ADDR_W-1:0] fetch_pc_i,
  output logic [`LSU_DATA_W-1:0] fetch_instr_o,
  output logic [`LSU_ADDR_W-1:0] fetch_addr_o,
  output logic                   fetch_valid_o
);

  import lsu_pkg::*;

  bus_req_t lsu_req;
  bus_req_t fetch_req;
  bus_req_t mem_req;
  bus_rsp_t lsu_rsp;
  bus_rsp_t fetch_rsp;
  bus_rsp_t mem_rsp;

  lsu_unit u_lsu_unit (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lsu_valid_i (lsu_valid_i),
    .lsu_op_i    (lsu_op_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_rdata_o (lsu_rdata_o),
    .lsu_done_o  (lsu_done_o),
    .bus_req_o   (lsu_req),
    .bus_rsp_i   (lsu_rsp)
  );

  fetch_port u_fetch_port (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_en_i    (fetch_en_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_o (fetch_instr_o),
    .fetch_addr_o  (fetch_addr_o),
    .fetch_valid_o (fetch_valid_o),
    .bus_req_o     (fetch_req),
    .bus_rsp_i     (fetch_rsp)
  );

  bus_arbiter u_bus_arbiter (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lsu_req_i   (lsu_req),
    .fetch_req_i (fetch_req),
    .lsu_rsp_o   (lsu_rsp),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  data_mem u_data_mem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

endmodule

// ==== verif/mem_subsys_asserts.sv ====
`timescale 1ns/10ps

module mem_subsys_asserts (
  input  logic              clk,
  input  logic              rst_n_i,
  input  lsu_pkg::bus_req_t lsu_req_i,
  input  lsu_pkg::bus_req_t fetch_req_i,
  input  lsu_pkg::bus_rsp_t lsu_rsp_i,
  input  lsu_pkg::bus_rsp_t fetch_rsp_i,
  input  logic              pulse_i
);

  // done only to a single requesting peer
  done_one_peer: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(lsu_rsp_i.done && fetch_rsp_i.done) &&
    (!lsu_rsp_i.done || lsu_req_i.valid) &&
    (!fetch_rsp_i.done || fetch_req_i.valid))
  else $error("done returned to both peers or to a peer without a request");

  lsu_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_req_i.valid && !lsu_rsp_i.done |=> $stable(lsu_req_i))
  else $error("lsu request changed before its done");

  fetch_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    fetch_req_i.valid && !fetch_rsp_i.done |=> $stable(fetch_req_i))
  else $error("fetch request changed before its done");

  // done is a single cycle pulse
  done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    pulse_i |=> !pulse_i)
  else $error("done pulse held longer than one cycle");

endmodule

bind bus_arbiter mem_subsys_asserts u_arb_asserts (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .lsu_req_i   (lsu_req_i),
  .fetch_req_i (fetch_req_i),
  .lsu_rsp_i   (lsu_rsp_o),
  .fetch_rsp_i (fetch_rsp_o),
  .pulse_i     (lsu_rsp_o.done)
);

// no fetch peer at this level
bind lsu_unit mem_subsys_asserts u_lsu_asserts (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .lsu_req_i   (bus_req_o),
  .fetch_req_i ('0),
  .lsu_rsp_i   (bus_rsp_i),
  .fetch_rsp_i ('0),
  .pulse_i     (lsu_done_o)
);

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module mem_subsys_tb;

  import lsu_pkg::*;

  localparam logic [31:0] FETCH_BASE = 32'h0000_0800;
  localparam int N_FETCH    = 24;
  localparam int RAND_WORDS = 32;
  localparam int N_RAND     = 40;
  // all lsu requests of the run
  localparam int N_REQ      = 7 * 15 + 9 + N_FETCH + RAND_WORDS + N_RAND;
  // idle gap, wait behind one fetch, own bus transaction
  localparam int WORST      = N_REQ * 6 + N_FETCH * 4 + 20;
  localparam int LIMIT      = 4 * WORST;

  logic                   clk = 1'b0;
  logic                   rst_n_i;
  logic                   lsu_valid_i;
  mem_op_e                lsu_op_i;
  logic [`LSU_ADDR_W-1:0] lsu_addr_i;
  logic [`LSU_DATA_W-1:0] lsu_wdata_i;
  logic [`LSU_DATA_W-1:0] lsu_rdata_o;
  logic                   lsu_done_o;
  logic                   fetch_en_i;
  logic [`LSU_ADDR_W-1:0] fetch_pc_i;
  logic [`LSU_DATA_W-1:0] fetch_instr_o;
  logic [`LSU_ADDR_W-1:0] fetch_addr_o;
  logic                   fetch_valid_o;

  logic [`LSU_DATA_W-1:0] shadow [`DMEM_WORDS];
  int                     fetch_count = 0;
  int                     cycles = 0;

  mem_subsys_top u_mem_subsys_top (.*);

  always #20 clk = ~clk;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic int word_index(input logic [31:0] a);
    return int'((a >> 2) % `DMEM_WORDS);
  endfunction

  // expected load value from a memory word
  function automatic logic [31:0] ref_load(input logic [31:0] w, input mem_op_e op,
                                           input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(w >> (8 * off));
    h = 16'(w >> (8 * off));
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'd0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'd0, h};
      default: return w;
    endcase
  endfunction

  // low bytes of the store data land at the byte offset
  function automatic void store_shadow(input mem_op_e op, input logic [31:0] a,
                                       input logic [31:0] d);
    int nbytes;
    int off;
    int w;
    nbytes = (op == SB) ? 1 : (op == SH) ? 2 : 4;
    off    = int'(a[1:0]);
    w      = word_index(a);
    for (int i = 0; i < nbytes; i++)
      shadow[w][8*(off+i) +: 8] = d[8*i +: 8];
  endfunction

  task automatic lsu_access(input mem_op_e op, input logic [31:0] a, input logic [31:0] d,
                            output int lat);
    @(negedge clk);
    lsu_valid_i = 1'b1;
    lsu_op_i    = op;
    lsu_addr_i  = a;
    lsu_wdata_i = d;
    lat = 0;
    do
    begin
      @(posedge clk);
      lat++;
    end
    while (lsu_done_o !== 1'b1);
    @(negedge clk);
    lsu_valid_i = 1'b0;
    lsu_op_i    = NONE;
  endtask

  task automatic random_access();
    mem_op_e     op;
    logic [31:0] a;
    int          lat;
    op = mem_op_e'(4'($urandom_range(1, 8)));
    a  = 32'($urandom_range(0, RAND_WORDS - 1) * 4);
    if (op inside {LB, LBU, SB})
      a = a + 32'($urandom_range(0, 3));
    else if (op inside {LH, LHU, SH})
      a = a + 32'($urandom_range(0, 1) * 2);
    lsu_access(op, a, $urandom, lat);
  endtask

  // compare process
  always @(posedge clk)
  begin
    if (rst_n_i && lsu_done_o)
    begin
      if (lsu_op_i inside {LB, LBU, LH, LHU, LW})
        check_value(lsu_rdata_o,
                    ref_load(shadow[word_index(lsu_addr_i)], lsu_op_i, lsu_addr_i[1:0]),
                    $sformatf("%s at %h", lsu_op_i.name(), lsu_addr_i));
      else
        store_shadow(lsu_op_i, lsu_addr_i, lsu_wdata_i);
    end
    if (rst_n_i && fetch_valid_o)
    begin
      // words arrive in order from the start address
      check_value(fetch_addr_o, FETCH_BASE + 32'(fetch_count * 4), "fetch address");
      check_value(fetch_instr_o, shadow[word_index(fetch_addr_o)],
                  $sformatf("fetch at %h", fetch_addr_o));
      fetch_count++;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("timeout: run went past %0d cycles without finishing", LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    int          lat;
    mem_op_e     op;
    int          off;
    logic [31:0] base;
    void'($urandom(32'hac92_4e9b));
    rst_n_i     = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_op_i    = NONE;
    lsu_addr_i  = '0;
    lsu_wdata_i = '0;
    fetch_en_i  = 1'b0;
    fetch_pc_i  = '0;
    repeat (4) @(negedge clk);
    rst_n_i = 1'b1;

    // quiet after reset
    repeat (8)
    begin
      @(posedge clk);
      check_value(32'(lsu_done_o), 32'd0, "lsu done while idle");
      check_value(32'(fetch_valid_o), 32'd0, "fetch valid while idle");
    end

    // every store size and offset, then every load
    for (int c = 0; c < 7; c++)
    begin
      op   = (c < 4) ? SB : (c < 6) ? SH : SW;
      off  = (c < 4) ? c : (c < 6) ? (c - 4) * 2 : 0;
      base = 32'h100 + c * 4;
      lsu_access(SW, base, $urandom, lat);
      lsu_access(op, base + off, $urandom, lat);
      for (int o = 0; o < 4; o++)
      begin
        lsu_access(LB, base + o, '0, lat);
        lsu_access(LBU, base + o, '0, lat);
        if (o % 2 == 0)
        begin
          lsu_access(LH, base + o, '0, lat);
          lsu_access(LHU, base + o, '0, lat);
        end
        if (o == 0)
          lsu_access(LW, base, '0, lat);
      end
    end

    // hits answer in the cycle of the request
    lsu_access(SW, 32'h200, 32'h8765_4321, lat);
    lsu_access(LW, 32'h200, '0, lat);
    lsu_access(LH, 32'h202, '0, lat);
    check_value(32'(lat), 32'd1, "halfword hit latency");
    lsu_access(LW, 32'h200, '0, lat);
    check_value(32'(lat), 32'd1, "word hit latency");

    // store to a cached word
    lsu_access(SW, 32'h204, 32'h1357_9bdf, lat);
    lsu_access(LW, 32'h204, '0, lat);
    lsu_access(LW, 32'h204, '0, lat);
    check_value(32'(lat), 32'd1, "hit before store");
    lsu_access(SW, 32'h204, 32'hfeed_0042, lat);
    lsu_access(LW, 32'h204, '0, lat);

    // fetch region and random region
    for (int i = 0; i < N_FETCH; i++)
      lsu_access(SW, FETCH_BASE + i * 4, $urandom, lat);
    for (int i = 0; i < RAND_WORDS; i++)
      lsu_access(SW, i * 4, $urandom, lat);

    fork
      begin
        @(negedge clk);
        fetch_pc_i = FETCH_BASE;
        fetch_en_i = 1'b1;
        wait (fetch_count >= N_FETCH);
        @(negedge clk);
        fetch_en_i = 1'b0;
      end
      begin
        for (int i = 0; i < N_RAND; i++)
          random_access();
      end
    join
    repeat (8) @(posedge clk);
    check_value(32'(fetch_count), N_FETCH, "fetched word count");

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
source/lsu_pkg.sv
source/lsu_l1d.sv
source/lsu_unit.sv
source/fetch_port.sv
source/bus_arbiter.sv
source/data_mem.sv
source/mem_subsys_top.sv
verif/mem_subsys_asserts.sv
verif/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_subsys_tb \
  -f verilog.f -o mem_subsys_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
